//--- timing_pkg.sv
package timing_pkg;

	////////////////////////////////
	// counter widths
	////////////////////////////////

	// position counters, horizontal and vertical
	localparam int h_width = 9;
	localparam int v_width = 9;

	// host-visible frame counter
	localparam int frame_width = 16;

	////////////////////////////////
	// horizontal geometry
	////////////////////////////////

	// pixels per line, counts 0..383
	localparam logic [h_width-1:0] h_total = 9'd384;

	// blank low window, inclusive
	localparam logic [h_width-1:0] h_blank_start = 9'd272;
	localparam logic [h_width-1:0] h_blank_end = 9'd367;

	// sync low window, inclusive
	localparam logic [h_width-1:0] h_sync_start = 9'd304;
	localparam logic [h_width-1:0] h_sync_end = 9'd335;

	////////////////////////////////
	// vertical geometry
	////////////////////////////////

	// lines per frame, counts 0..263
	localparam logic [v_width-1:0] v_total = 9'd264;

	// blank low from start to end of frame, and again up to v_blank_end
	localparam logic [v_width-1:0] v_blank_start = 9'd240;
	localparam logic [v_width-1:0] v_blank_end = 9'd15;

	// sync low from here to the last line
	localparam logic [v_width-1:0] v_sync_start = 9'd248;

	////////////////////////////////
	// register map, word addresses
	////////////////////////////////

	localparam logic [1:0] reg_addr_pos = 2'd0;
	localparam logic [1:0] reg_addr_frame = 2'd1;
	localparam logic [1:0] reg_addr_cmp = 2'd2;
	localparam logic [1:0] reg_addr_stat = 2'd3;

endpackage

//--- clock_enable_gen.sv
`timescale 1ns/100ps

module clock_enable_gen (
	input  logic CLK_48M,
	input  logic rst,
	output logic ce_24m,
	output logic ce_12m,
	output logic ce_6m
);

	////////////////////////////////
	// free-running divider
	////////////////////////////////

	// 3-bit count, one step per 48 MHz clock
	logic [2:0] div;
	logic [2:0] div_next;

	// wraps 7 -> 0 by itself
	assign div_next = div + 3'd1;

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			div <= 3'd0;
		end else begin
			div <= div_next;
		end
	end

	////////////////////////////////
	// strobe decode
	////////////////////////////////

	// decoded from next count so each strobe is high while div holds the value
	// 24 MHz: odd counts
	// 12 MHz: counts 3 and 7
	// 6 MHz: count 7 only, eighth clock after reset
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			ce_24m <= 1'b0;
			ce_12m <= 1'b0;
			ce_6m <= 1'b0;
		end else begin
			ce_24m <= div_next[0];
			ce_12m <= (div_next[1:0] == 2'b11);
			ce_6m <= (div_next == 3'd7);
		end
	end

endmodule

//--- horiz_timing.sv
`timescale 1ns/100ps

module horiz_timing (
	input  logic CLK_48M,
	input  logic rst,
	input  logic ce_6m,
	output logic [timing_pkg::h_width-1:0] h_count,
	output logic hsync_n,
	output logic hblank_n,
	output logic line_start
);

	import timing_pkg::*;

	////////////////////////////////
	// next-count logic
	////////////////////////////////

	// next pixel position and wrap detect
	logic [h_width-1:0] h_next;
	logic h_wrap;

	// last pixel of the line
	assign h_wrap = (h_count == h_total - 1'b1);

	// back to 0 after 383
	assign h_next = h_wrap ? '0 : h_count + 1'b1;

	////////////////////////////////
	// level decode
	////////////////////////////////

	// sync and blank levels for the next position
	logic sync_next;
	logic blank_next;

	// low inside the sync window
	assign sync_next = ~((h_next >= h_sync_start) && (h_next <= h_sync_end));

	// low inside the blank window, sync sits inside it
	assign blank_next = ~((h_next >= h_blank_start) && (h_next <= h_blank_end));

	////////////////////////////////
	// pixel counter
	////////////////////////////////

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			h_count <= '0;
		end else if (ce_6m) begin
			h_count <= h_next;
		end
	end

	////////////////////////////////
	// registered outputs
	////////////////////////////////

	// levels move on the same clock as the counter
	// so they line up with h_count with no offset
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			hsync_n <= 1'b1;
			hblank_n <= 1'b1;
		end else if (ce_6m) begin
			hsync_n <= sync_next;
			hblank_n <= blank_next;
		end
	end

	// one-clock strobe, high together with h_count == 0 after a wrap
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			line_start <= 1'b0;
		end else begin
			line_start <= ce_6m && h_wrap;
		end
	end

endmodule

//--- vert_timing.sv
`timescale 1ns/100ps

module vert_timing (
	input  logic CLK_48M,
	input  logic rst,
	input  logic line_start,
	output logic [timing_pkg::v_width-1:0] v_count,
	output logic vsync_n,
	output logic vblank_n,
	output logic vreset_n,
	output logic frame_start
);

	import timing_pkg::*;

	////////////////////////////////
	// next-line logic
	////////////////////////////////

	// next line number and frame wrap detect
	logic [v_width-1:0] v_next;
	logic v_wrap;

	// last line of the frame
	assign v_wrap = (v_count == v_total - 1'b1);

	// back to line 0 after 263
	assign v_next = v_wrap ? '0 : v_count + 1'b1;

	////////////////////////////////
	// level decode
	////////////////////////////////

	logic sync_next;
	logic blank_next;
	logic reset_next;

	// sync low from 248 up to the last line
	assign sync_next = ~(v_next >= v_sync_start);

	// blank spans the wrap, so two ranges
	assign blank_next = ~((v_next >= v_blank_start) || (v_next <= v_blank_end));

	// vertical reset low for all of line 0
	assign reset_next = (v_next != '0);

	////////////////////////////////
	// line counter
	////////////////////////////////

	// line_start replaces the old sync-edge clock
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			v_count <= '0;
		end else if (line_start) begin
			v_count <= v_next;
		end
	end

	////////////////////////////////
	// registered outputs
	////////////////////////////////

	// levels follow v_count with zero offset
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			vsync_n <= 1'b1;
			vblank_n <= 1'b1;
			vreset_n <= 1'b1;
		end else if (line_start) begin
			vsync_n <= sync_next;
			vblank_n <= blank_next;
			vreset_n <= reset_next;
		end
	end

	// one-clock strobe, lands with v_count == 0 after a wrap
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			frame_start <= 1'b0;
		end else begin
			frame_start <= line_start && v_wrap;
		end
	end

endmodule

//--- timing_regs.sv
`timescale 1ns/100ps

module timing_regs (
	input  logic CLK_48M,
	input  logic rst,
	input  logic [timing_pkg::h_width-1:0] h_count,
	input  logic [timing_pkg::v_width-1:0] v_count,
	input  logic line_start,
	input  logic frame_start,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [1:0] wb_adr,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack,
	output logic irq
);

	import timing_pkg::*;

	////////////////////////////////
	// bus decode
	////////////////////////////////

	// new request, blocked while ack is out so ack stays one clock
	logic req;
	logic wr_cmp;
	logic wr_stat;

	assign req = wb_cyc && wb_stb && !wb_ack;
	assign wr_cmp = req && wb_we && (wb_adr == reg_addr_cmp);
	assign wr_stat = req && wb_we && (wb_adr == reg_addr_stat);

	// ack one clock after the request, never stalls
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;
		end
	end

	////////////////////////////////
	// frame counter
	////////////////////////////////

	logic [frame_width-1:0] frame_cnt;

	// counts frame_start, wraps at full scale
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			frame_cnt <= '0;
		end else if (frame_start) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	////////////////////////////////
	// line compare
	////////////////////////////////

	logic [v_width-1:0] cmp_line;
	logic [v_width-1:0] line_next;
	logic pending;
	logic hit;

	// line the vertical counter moves to on this line_start
	assign line_next = (v_count == v_total - 1'b1) ? '0 : v_count + 1'b1;
	assign hit = line_start && (line_next == cmp_line);

	// compare line, low 9 bits of the write data
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			cmp_line <= '0;
		end else if (wr_cmp) begin
			cmp_line <= wb_dat_i[v_width-1:0];
		end
	end

	// pending flag, set beats clear
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (hit) begin
			pending <= 1'b1;
		end else if (wr_stat && wb_dat_i[0]) begin
			pending <= 1'b0;
		end
	end

	assign irq = pending;

	////////////////////////////////
	// read data
	////////////////////////////////

	// captured on the request clock, returned with ack
	// position is the beam as seen on that clock
	always_ff @(posedge CLK_48M) begin
		if (req && !wb_we) begin
			case (wb_adr)
				reg_addr_pos:
					wb_dat_o <= {{(16 - v_width){1'b0}}, v_count,
						{(16 - h_width){1'b0}}, h_count};
				reg_addr_frame:
					wb_dat_o <= {{(32 - frame_width){1'b0}}, frame_cnt};
				reg_addr_cmp:
					wb_dat_o <= {{(32 - v_width){1'b0}}, cmp_line};
				reg_addr_stat:
					wb_dat_o <= {31'd0, pending};
				default:
					wb_dat_o <= 32'd0;
			endcase
		end
	end

endmodule

//--- video_timing_top.sv
`timescale 1ns/100ps

module video_timing_top (
	input  logic CLK_48M,
	input  logic rst,
	// host bus
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [1:0] wb_adr,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack,
	// pixel rate strobes
	output logic ce_24m,
	output logic ce_12m,
	output logic ce_6m,
	// beam position and video sync
	output logic [timing_pkg::h_width-1:0] h_count,
	output logic [timing_pkg::v_width-1:0] v_count,
	output logic hsync_n,
	output logic hblank_n,
	output logic vsync_n,
	output logic vblank_n,
	output logic vreset_n,
	output logic irq
);

	// line and frame strobes between counters and registers
	logic line_start;
	logic frame_start;

	////////////////////////////////
	// enable generation
	////////////////////////////////

	clock_enable_gen u_ce (
		.CLK_48M (CLK_48M),
		.rst     (rst),
		.ce_24m  (ce_24m),
		.ce_12m  (ce_12m),
		.ce_6m   (ce_6m)
	);

	////////////////////////////////
	// beam counters
	////////////////////////////////

	// pixel counter on the 6 MHz enable
	horiz_timing u_horiz (
		.CLK_48M    (CLK_48M),
		.rst        (rst),
		.ce_6m      (ce_6m),
		.h_count    (h_count),
		.hsync_n    (hsync_n),
		.hblank_n   (hblank_n),
		.line_start (line_start)
	);

	// line counter, one step per line
	vert_timing u_vert (
		.CLK_48M     (CLK_48M),
		.rst         (rst),
		.line_start  (line_start),
		.v_count     (v_count),
		.vsync_n     (vsync_n),
		.vblank_n    (vblank_n),
		.vreset_n    (vreset_n),
		.frame_start (frame_start)
	);

	////////////////////////////////
	// host registers
	////////////////////////////////

	timing_regs u_regs (
		.CLK_48M     (CLK_48M),
		.rst         (rst),
		.h_count     (h_count),
		.v_count     (v_count),
		.line_start  (line_start),
		.frame_start (frame_start),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack      (wb_ack),
		.irq         (irq)
	);

endmodule

//--- tb_video_timing_ref.svh
`ifndef TB_VIDEO_TIMING_REF_SVH
`define TB_VIDEO_TIMING_REF_SVH

////////////////////////////////
// expected video levels
////////////////////////////////

// hsync low from 304 through 335
function automatic logic exp_hsync(input logic [h_width-1:0] h);
	return !((h >= h_sync_start) && (h <= h_sync_end));
endfunction

// hblank low from 272 through 367
function automatic logic exp_hblank(input logic [h_width-1:0] h);
	return !((h >= h_blank_start) && (h <= h_blank_end));
endfunction

// vsync low from 248 to the end of the frame
function automatic logic exp_vsync(input logic [v_width-1:0] v);
	return !(v >= v_sync_start);
endfunction

// vblank low at the bottom of the frame and over the top 16 lines
function automatic logic exp_vblank(input logic [v_width-1:0] v);
	return !((v >= v_blank_start) || (v <= v_blank_end));
endfunction

// vreset low only on line 0
function automatic logic exp_vreset(input logic [v_width-1:0] v);
	return (v != 0);
endfunction

////////////////////////////////
// expected register words
////////////////////////////////

// position word, v in 24..16, h in 8..0
function automatic logic [31:0] exp_pos_word(input logic [h_width-1:0] h,
		input logic [v_width-1:0] v);
	logic [31:0] word;
	word = 32'd0;
	word[24:16] = v;
	word[8:0] = h;
	return word;
endfunction

`endif

//--- tb_video_timing.sv
`timescale 1ns/100ps

module tb_video_timing;

	import timing_pkg::*;

	`include "tb_video_timing_ref.svh"

	// stand-in for the 48 MHz clock, inputs move 1 ns after the edge
	localparam int clk_period = 8;
	localparam int drive_delay = 1;
	// eight clocks per pixel
	localparam int line_clocks = h_total * 8;
	localparam int frame_clocks = line_clocks * v_total;
	// two frames, bus traffic and a quarter frame of slack
	localparam int run_clocks = 2 * frame_clocks + frame_clocks / 4 + 20000;

	logic CLK_48M;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic wb_ack;
	logic ce_24m;
	logic ce_12m;
	logic ce_6m;
	logic [h_width-1:0] h_count;
	logic [v_width-1:0] v_count;
	logic hsync_n;
	logic hblank_n;
	logic vsync_n;
	logic vblank_n;
	logic vreset_n;
	logic irq;

	// model state, advanced once per rising edge
	logic [2:0] m_div;
	logic [h_width-1:0] m_h;
	logic [v_width-1:0] m_v;
	logic m_line_start;
	logic m_frame_start;
	logic m_v_loaded;
	logic [frame_width-1:0] m_frames;
	logic model_valid;

	video_timing_top UUT (
		.CLK_48M  (CLK_48M),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack),
		.ce_24m   (ce_24m),
		.ce_12m   (ce_12m),
		.ce_6m    (ce_6m),
		.h_count  (h_count),
		.v_count  (v_count),
		.hsync_n  (hsync_n),
		.hblank_n (hblank_n),
		.vsync_n  (vsync_n),
		.vblank_n (vblank_n),
		.vreset_n (vreset_n),
		.irq      (irq)
	);

	initial begin
		CLK_48M = 1'b0;
		forever #(clk_period / 2) CLK_48M = ~CLK_48M;
	end

	////////////////////////////////
	// check and model
	////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// one clock of divider, pixel, line and frame counting
	task automatic step_model(input logic rst_s);
		logic ce6_old;
		logic ls_old;
		logic fs_old;
		logic h_wrap;
		logic v_wrap;
		ce6_old = (m_div == 3'd7);
		ls_old = m_line_start;
		fs_old = m_frame_start;
		h_wrap = (m_h == h_total - 1);
		v_wrap = (m_v == v_total - 1);
		if (rst_s) begin
			m_div = 3'd0;
			m_h = '0;
			m_v = '0;
			m_line_start = 1'b0;
			m_frame_start = 1'b0;
			m_v_loaded = 1'b0;
			m_frames = '0;
			model_valid = 1'b1;
		end else if (model_valid) begin
			// strobes rise on the same edge as the wrap
			m_line_start = ce6_old && h_wrap;
			m_frame_start = ls_old && v_wrap;
			if (ce6_old)
				m_h = h_wrap ? '0 : m_h + 1'b1;
			if (ls_old) begin
				m_v = v_wrap ? '0 : m_v + 1'b1;
				m_v_loaded = 1'b1;
			end
			if (fs_old)
				m_frames = m_frames + 1'b1;
			m_div = m_div + 3'd1;
		end
	endtask

	task automatic compare_outputs();
		check_value("enable ce_24m", m_div[0], ce_24m);
		check_value("enable ce_12m", m_div[1:0] == 2'b11, ce_12m);
		check_value("enable ce_6m", m_div == 3'd7, ce_6m);
		check_value("h_count", m_h, h_count);
		check_value("v_count", m_v, v_count);
		check_value("hsync_n", exp_hsync(m_h), hsync_n);
		check_value("hblank_n", exp_hblank(m_h), hblank_n);
		// vertical levels hold their reset value until the first line step
		check_value("vsync_n", m_v_loaded ? exp_vsync(m_v) : 1'b1, vsync_n);
		check_value("vblank_n", m_v_loaded ? exp_vblank(m_v) : 1'b1, vblank_n);
		check_value("vreset_n", m_v_loaded ? exp_vreset(m_v) : 1'b1, vreset_n);
	endtask

	// model steps on the edge, DUT compared at the falling edge
	initial begin
		model_valid = 1'b0;
		forever begin
			@(posedge CLK_48M);
			step_model(rst);
			@(negedge CLK_48M);
			if (model_valid)
				compare_outputs();
		end
	end

	////////////////////////////////
	// bus helpers
	////////////////////////////////

	task automatic wait_drive_point();
		@(posedge CLK_48M);
		#drive_delay;
	endtask

	// one classic cycle, snaps hold the model before the request edge
	task automatic bus_access(input logic we, input logic [1:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata,
			output logic [h_width-1:0] snap_h, output logic [v_width-1:0] snap_v,
			output logic [frame_width-1:0] snap_frames);
		logic acked;
		int waits;
		acked = 1'b0;
		waits = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_i = wdata;
		while (!acked) begin
			snap_h = m_h;
			snap_v = m_v;
			snap_frames = m_frames;
			wait_drive_point();
			waits++;
			acked = wb_ack;
		end
		rdata = wb_dat_o;
		check_value("wishbone ack latency", 1, waits);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wait_drive_point();
		// ack is one clock wide
		check_value("wishbone ack width", 0, wb_ack);
	endtask

	////////////////////////////////
	// test sequence
	////////////////////////////////

	initial begin
		int unsigned seed_val;
		int n;
		logic [31:0] rdata;
		logic [31:0] wdata;
		logic [h_width-1:0] snap_h;
		logic [v_width-1:0] snap_v;
		logic [frame_width-1:0] snap_f;
		logic [v_width-1:0] cmp_val;
		logic [v_width-1:0] prev_v;
		logic done;
		seed_val = $urandom(32'hcbab);
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 2'd0;
		wb_dat_i = 32'd0;
		repeat (2) @(posedge CLK_48M);
		#drive_delay;
		rst = 1'b0;

		// first pixel step lands on the eighth edge
		n = 0;
		while (h_count == 0) begin
			wait_drive_point();
			n++;
		end
		check_value("first ce_6m clock", 8, n);

		// position reads at random points of the line
		repeat (6) begin
			repeat ($urandom % 400) wait_drive_point();
			bus_access(1'b0, reg_addr_pos, 32'd0, rdata, snap_h, snap_v, snap_f);
			check_value("position read", exp_pos_word(snap_h, snap_v), rdata);
		end
		bus_access(1'b0, reg_addr_frame, 32'd0, rdata, snap_h, snap_v, snap_f);
		check_value("frame counter read", snap_f, rdata);

		// compare line, junk in the upper write bits
		cmp_val = $urandom % v_total;
		wdata = ($urandom & ~32'h1ff) | cmp_val;
		bus_access(1'b1, reg_addr_cmp, wdata, rdata, snap_h, snap_v, snap_f);
		bus_access(1'b0, reg_addr_cmp, 32'd0, rdata, snap_h, snap_v, snap_f);
		check_value("compare line readback", cmp_val, rdata);

		while (m_frames < 1)
			wait_drive_point();
		bus_access(1'b0, reg_addr_frame, 32'd0, rdata, snap_h, snap_v, snap_f);
		check_value("frame counter after one frame", snap_f, rdata);

		// clear mid-line, well away from any line_start
		while (m_h != 100)
			wait_drive_point();
		bus_access(1'b1, reg_addr_stat, 32'd1, rdata, snap_h, snap_v, snap_f);
		check_value("irq after clear", 0, irq);
		bus_access(1'b0, reg_addr_stat, 32'd0, rdata, snap_h, snap_v, snap_f);
		check_value("status after clear", 0, rdata);

		// irq stays low until v_count steps onto the compare line
		done = 1'b0;
		while (!done) begin
			prev_v = m_v;
			wait_drive_point();
			if (m_v == cmp_val && prev_v != cmp_val) begin
				check_value("irq on compare line", 1, irq);
				done = 1'b1;
			end else begin
				check_value("irq before compare line", 0, irq);
			end
		end

		while (m_h != 100)
			wait_drive_point();
		bus_access(1'b0, reg_addr_stat, 32'd0, rdata, snap_h, snap_v, snap_f);
		check_value("status pending", 1, rdata);
		bus_access(1'b1, reg_addr_stat, 32'd1, rdata, snap_h, snap_v, snap_f);
		check_value("irq after second clear", 0, irq);
		bus_access(1'b0, reg_addr_stat, 32'd0, rdata, snap_h, snap_v, snap_f);
		check_value("status after second clear", 0, rdata);

		// two whole frames seen by the counter
		while (m_frames < 2)
			wait_drive_point();
		bus_access(1'b0, reg_addr_frame, 32'd0, rdata, snap_h, snap_v, snap_f);
		check_value("frame counter after two frames", snap_f, rdata);
		bus_access(1'b0, reg_addr_pos, 32'd0, rdata, snap_h, snap_v, snap_f);
		check_value("final position read", exp_pos_word(snap_h, snap_v), rdata);

		$display("TEST OK");
		$finish;
	end

	// watchdog
	initial begin
		#(run_clocks * clk_period);
		$display("timeout: the run did not finish within %0d clocks", run_clocks);
		$display("TEST FAILED");
		$fatal(1);
	end

endmodule

//--- filelist.f
+incdir+.
timing_pkg.sv
clock_enable_gen.sv
horiz_timing.sv
vert_timing.sv
timing_regs.sv
video_timing_top.sv
tb_video_timing.sv
